/* logic/switch_pkg.sv */
package switch_pkg;

    // switch geometry
    localparam int NUM_PORTS = 4;
    // port index, one-hot masks use NUM_PORTS bits
    localparam int PORT_W = $clog2(NUM_PORTS);

    // ingress byte stream
    localparam int DATA_WIDTH = 8;

    // frame length counter, saturates at 2047
    localparam int LEN_W = 11;

    // dst + src mac bytes at the head of a frame
    localparam int HDR_BYTES = 12;
    // runt limit, anything shorter is dropped
    localparam int MIN_FRAME_BYTES = 14;

    // forwarding descriptor queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // descriptor word = {mask, src port, length}
    localparam int DESC_W = NUM_PORTS + PORT_W + LEN_W;

endpackage

/* logic/mac_pkg.sv */
package mac_pkg;

    // ethernet mac address width
    localparam int MAC_W = 48;

    // mac address, first octet on the wire sits in [47:40]
    // raw view for table compare, field view for address class
    typedef union packed {
        logic [MAC_W-1:0] raw;
        struct packed {
            // upper six bits of the first octet
            logic [5:0]  oui_hi;
            // locally administered
            logic        local_bit;
            // multicast / broadcast
            logic        group_bit;
            // remaining five octets
            logic [39:0] tail;
        } f;
    } mac_addr_u;

    // learned station table
    localparam int TABLE_ENTRIES = 16;
    localparam int TABLE_IDX_W = $clog2(TABLE_ENTRIES);

endpackage

/* logic/frame_header_parser.sv */
`timescale 1ns/1ps

module frame_header_parser (
    input  logic                              switch_clk,
    input  logic                              rst_n_i,
    input  logic [switch_pkg::DATA_WIDTH-1:0] rx_data_i,
    input  logic                              rx_valid_i,
    input  logic                              rx_sof_i,
    input  logic                              rx_eof_i,
    input  logic                              rx_error_i,
    output logic                              rx_ready_o,
    output logic                              hdr_valid_o,
    input  logic                              hdr_ready_i,
    output mac_pkg::mac_addr_u                dst_addr_o,
    output mac_pkg::mac_addr_u                src_addr_o,
    output logic [switch_pkg::LEN_W-1:0]      frame_len_o
);
    import switch_pkg::*;
    import mac_pkg::*;

    // bytes seen so far in the current frame
    logic [LEN_W-1:0] byte_cnt_q;
    // sticky receive error
    logic             err_q;

    logic             beat;
    logic [LEN_W-1:0] byte_idx;
    logic [LEN_W-1:0] beat_len;
    logic             frame_err;
    logic             frame_good;

    // header regs double as capture regs, so hold off the next frame
    // until the arbiter takes the pending header
    assign rx_ready_o = !hdr_valid_o;
    assign beat       = rx_valid_i && rx_ready_o;

    // sof restarts the byte index
    assign byte_idx = rx_sof_i ? '0 : byte_cnt_q;
    // saturate at all ones
    assign beat_len = (&byte_idx) ? byte_idx : byte_idx + LEN_W'(1);

    // error on this beat or any earlier beat of the frame
    assign frame_err  = (err_q && !rx_sof_i) || rx_error_i;
    assign frame_good = !frame_err && (beat_len >= LEN_W'(MIN_FRAME_BYTES));

    always_ff @(posedge switch_clk) begin
        if (!rst_n_i) begin
            byte_cnt_q <= '0;
            err_q      <= 1'b0;
        end else if (beat) begin
            byte_cnt_q <= rx_eof_i ? '0 : beat_len;
            err_q      <= rx_eof_i ? 1'b0 : frame_err;
        end
    end

    // header valid the cycle after the eof beat, bad frames vanish here
    always_ff @(posedge switch_clk) begin
        if (!rst_n_i) begin
            hdr_valid_o <= 1'b0;
        end else if (hdr_valid_o && hdr_ready_i) begin
            hdr_valid_o <= 1'b0;
        end else if (beat && rx_eof_i) begin
            hdr_valid_o <= frame_good;
        end
    end

    // bytes 0-5 dst, 6-11 src, msb first
    always_ff @(posedge switch_clk) begin
        if (beat) begin
            if (byte_idx < LEN_W'(HDR_BYTES / 2)) begin
                dst_addr_o.raw <= {dst_addr_o.raw[MAC_W-DATA_WIDTH-1:0], rx_data_i};
            end else if (byte_idx < LEN_W'(HDR_BYTES)) begin
                src_addr_o.raw <= {src_addr_o.raw[MAC_W-DATA_WIDTH-1:0], rx_data_i};
            end
            // length latched with the last byte
            if (rx_eof_i) begin
                frame_len_o <= beat_len;
            end
        end
    end

endmodule

/* logic/header_arbiter.sv */
`timescale 1ns/1ps

module header_arbiter (
    input  logic                              switch_clk,
    input  logic                              rst_n_i,
    input  logic                              hdr_valid_i [switch_pkg::NUM_PORTS],
    output logic                              hdr_ready_o [switch_pkg::NUM_PORTS],
    input  mac_pkg::mac_addr_u                dst_addr_i [switch_pkg::NUM_PORTS],
    input  mac_pkg::mac_addr_u                src_addr_i [switch_pkg::NUM_PORTS],
    input  logic [switch_pkg::LEN_W-1:0]      frame_len_i [switch_pkg::NUM_PORTS],
    output logic                              sel_valid_o,
    output logic [switch_pkg::PORT_W-1:0]     sel_port_o,
    output mac_pkg::mac_addr_u                sel_dst_o,
    output mac_pkg::mac_addr_u                sel_src_o,
    output logic [switch_pkg::LEN_W-1:0]      sel_len_o,
    input  logic                              sel_ready_i
);
    import switch_pkg::*;

    // next port to favour
    logic [PORT_W-1:0] rr_ptr_q;
    // grant frozen while the table stalls
    logic              lock_q;
    logic [PORT_W-1:0] lock_port_q;

    logic              found;
    logic [PORT_W-1:0] pick;
    logic              accept;

    // first requester at or after the pointer
    always_comb begin
        found = 1'b0;
        pick  = rr_ptr_q;
        for (int i = 0; i < NUM_PORTS; i++) begin
            logic [PORT_W-1:0] cand;
            cand = rr_ptr_q + PORT_W'(i);
            if (!found && hdr_valid_i[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    assign sel_port_o  = lock_q ? lock_port_q : pick;
    assign sel_valid_o = lock_q || found;
    assign sel_dst_o   = dst_addr_i[sel_port_o];
    assign sel_src_o   = src_addr_i[sel_port_o];
    assign sel_len_o   = frame_len_i[sel_port_o];
    assign accept      = sel_valid_o && sel_ready_i;

    // ready back only to the granted parser
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            hdr_ready_o[p] = accept && (sel_port_o == PORT_W'(p));
        end
    end

    always_ff @(posedge switch_clk) begin
        if (!rst_n_i) begin
            rr_ptr_q    <= '0;
            lock_q      <= 1'b0;
            lock_port_q <= '0;
        end else if (accept) begin
            // move past the winner
            rr_ptr_q <= sel_port_o + PORT_W'(1);
            lock_q   <= 1'b0;
        end else if (sel_valid_o) begin
            lock_q      <= 1'b1;
            lock_port_q <= sel_port_o;
        end
    end

endmodule

/* logic/address_table.sv */
`timescale 1ns/1ps

module address_table (
    input  logic                              switch_clk,
    input  logic                              rst_n_i,
    input  logic                              sel_valid_i,
    input  logic [switch_pkg::PORT_W-1:0]     sel_port_i,
    input  mac_pkg::mac_addr_u                sel_dst_i,
    input  mac_pkg::mac_addr_u                sel_src_i,
    input  logic [switch_pkg::LEN_W-1:0]      sel_len_i,
    output logic                              sel_ready_o,
    output logic                              fwd_valid_o,
    output logic [switch_pkg::NUM_PORTS-1:0]  fwd_mask_o,
    output logic [switch_pkg::PORT_W-1:0]     fwd_src_port_o,
    output logic [switch_pkg::LEN_W-1:0]      fwd_len_o,
    input  logic                              fwd_ready_i
);
    import switch_pkg::*;
    import mac_pkg::*;

    // station entries
    logic                   entry_valid_q [TABLE_ENTRIES];
    logic [MAC_W-1:0]       entry_mac_q [TABLE_ENTRIES];
    logic [PORT_W-1:0]      entry_port_q [TABLE_ENTRIES];
    // fifo-style replacement slot
    logic [TABLE_IDX_W-1:0] victim_q;

    logic                   dst_hit;
    logic [PORT_W-1:0]      dst_port;
    logic                   src_hit;
    logic [TABLE_IDX_W-1:0] src_idx;
    logic [NUM_PORTS-1:0]   flood_mask;
    logic                   filtered;
    logic                   learn;

    // parallel compare of dst and src against every entry
    // reads the table as it was before this frame's learn
    always_comb begin
        dst_hit  = 1'b0;
        dst_port = '0;
        src_hit  = 1'b0;
        src_idx  = '0;
        for (int i = 0; i < TABLE_ENTRIES; i++) begin
            if (!dst_hit && entry_valid_q[i] && entry_mac_q[i] == sel_dst_i.raw) begin
                dst_hit  = 1'b1;
                dst_port = entry_port_q[i];
            end
            if (!src_hit && entry_valid_q[i] && entry_mac_q[i] == sel_src_i.raw) begin
                src_hit = 1'b1;
                src_idx = TABLE_IDX_W'(i);
            end
        end
    end

    // every port but the ingress one
    assign flood_mask = ~(NUM_PORTS'(1) << sel_port_i);

    // group dst floods, then hit, then miss floods
    always_comb begin
        filtered   = 1'b0;
        fwd_mask_o = flood_mask;
        if (!sel_dst_i.f.group_bit && dst_hit) begin
            fwd_mask_o = NUM_PORTS'(1) << dst_port;
            // station lives on the ingress port
            filtered   = (dst_port == sel_port_i);
        end
    end

    // queue space gates acceptance, filtered headers still consume
    assign sel_ready_o    = fwd_ready_i;
    assign fwd_valid_o    = sel_valid_i && !filtered;
    assign fwd_src_port_o = sel_port_i;
    assign fwd_len_o      = sel_len_i;

    // group sources are never learned
    assign learn = sel_valid_i && sel_ready_o && !sel_src_i.f.group_bit;

    always_ff @(posedge switch_clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TABLE_ENTRIES; i++) begin
                entry_valid_q[i] <= 1'b0;
            end
            victim_q <= '0;
        end else if (learn && !src_hit) begin
            entry_valid_q[victim_q] <= 1'b1;
            // wraps after the last entry
            victim_q <= victim_q + TABLE_IDX_W'(1);
        end
    end

    // known station moves port in place, new one takes the victim slot
    always_ff @(posedge switch_clk) begin
        if (learn) begin
            if (src_hit) begin
                entry_port_q[src_idx] <= sel_port_i;
            end else begin
                entry_mac_q[victim_q]  <= sel_src_i.raw;
                entry_port_q[victim_q] <= sel_port_i;
            end
        end
    end

endmodule

/* logic/forward_queue.sv */
`timescale 1ns/1ps

module forward_queue (
    input  logic                              switch_clk,
    input  logic                              rst_n_i,
    input  logic                              fwd_valid_i,
    input  logic [switch_pkg::NUM_PORTS-1:0]  fwd_mask_i,
    input  logic [switch_pkg::PORT_W-1:0]     fwd_src_port_i,
    input  logic [switch_pkg::LEN_W-1:0]      fwd_len_i,
    output logic                              fwd_ready_o,
    output logic                              desc_valid_o,
    output logic [switch_pkg::NUM_PORTS-1:0]  desc_mask_o,
    output logic [switch_pkg::PORT_W-1:0]     desc_src_port_o,
    output logic [switch_pkg::LEN_W-1:0]      desc_len_o,
    input  logic                              desc_ready_i
);
    import switch_pkg::*;

    // descriptor storage
    logic [DESC_W-1:0]      mem_q [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [QUEUE_PTR_W-1:0] rd_ptr_q;
    // occupancy, one extra bit for full
    logic [QUEUE_PTR_W:0]   count_q;

    logic                   wr_en;
    logic                   rd_en;

    // full is judged before the edge, so no write-through on full
    assign fwd_ready_o  = (count_q != (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
    assign desc_valid_o = (count_q != '0);
    assign wr_en        = fwd_valid_i && fwd_ready_o;
    assign rd_en        = desc_valid_o && desc_ready_i;

    // head entry straight from the flops
    assign {desc_mask_o, desc_src_port_o, desc_len_o} = mem_q[rd_ptr_q];

    always_ff @(posedge switch_clk) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + QUEUE_PTR_W'(1);
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + QUEUE_PTR_W'(1);
            end
            // simultaneous read and write keeps the count
            if (wr_en && !rd_en) begin
                count_q <= count_q + (QUEUE_PTR_W + 1)'(1);
            end else if (rd_en && !wr_en) begin
                count_q <= count_q - (QUEUE_PTR_W + 1)'(1);
            end
        end
    end

    always_ff @(posedge switch_clk) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= {fwd_mask_i, fwd_src_port_i, fwd_len_i};
        end
    end

endmodule

/* logic/switch_core.sv */
`timescale 1ns/1ps

module switch_core (
    input  logic                              switch_clk,
    input  logic                              rst_n_i,
    // ingress byte streams, one per port
    input  logic [switch_pkg::DATA_WIDTH-1:0] rx_data_i [switch_pkg::NUM_PORTS],
    input  logic                              rx_valid_i [switch_pkg::NUM_PORTS],
    input  logic                              rx_sof_i [switch_pkg::NUM_PORTS],
    input  logic                              rx_eof_i [switch_pkg::NUM_PORTS],
    input  logic                              rx_error_i [switch_pkg::NUM_PORTS],
    output logic                              rx_ready_o [switch_pkg::NUM_PORTS],
    // forwarding descriptors toward the egress queues
    output logic                              desc_valid_o,
    output logic [switch_pkg::NUM_PORTS-1:0]  desc_mask_o,
    output logic [switch_pkg::PORT_W-1:0]     desc_src_port_o,
    output logic [switch_pkg::LEN_W-1:0]      desc_len_o,
    input  logic                              desc_ready_i
);
    import switch_pkg::*;
    import mac_pkg::*;

    // parser to arbiter
    logic             hdr_valid [NUM_PORTS];
    logic             hdr_ready [NUM_PORTS];
    mac_addr_u        hdr_dst [NUM_PORTS];
    mac_addr_u        hdr_src [NUM_PORTS];
    logic [LEN_W-1:0] hdr_len [NUM_PORTS];

    // arbiter to table
    logic              sel_valid;
    logic              sel_ready;
    logic [PORT_W-1:0] sel_port;
    mac_addr_u         sel_dst;
    mac_addr_u         sel_src;
    logic [LEN_W-1:0]  sel_len;

    // table to queue
    logic                 fwd_valid;
    logic                 fwd_ready;
    logic [NUM_PORTS-1:0] fwd_mask;
    logic [PORT_W-1:0]    fwd_src_port;
    logic [LEN_W-1:0]     fwd_len;

    // one header decoder per ingress port
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        frame_header_parser u_parser (
            .switch_clk  (switch_clk),
            .rst_n_i     (rst_n_i),
            .rx_data_i   (rx_data_i[p]),
            .rx_valid_i  (rx_valid_i[p]),
            .rx_sof_i    (rx_sof_i[p]),
            .rx_eof_i    (rx_eof_i[p]),
            .rx_error_i  (rx_error_i[p]),
            .rx_ready_o  (rx_ready_o[p]),
            .hdr_valid_o (hdr_valid[p]),
            .hdr_ready_i (hdr_ready[p]),
            .dst_addr_o  (hdr_dst[p]),
            .src_addr_o  (hdr_src[p]),
            .frame_len_o (hdr_len[p])
        );
    end

    // single shared lookup path
    header_arbiter u_arbiter (
        .switch_clk  (switch_clk),
        .rst_n_i     (rst_n_i),
        .hdr_valid_i (hdr_valid),
        .hdr_ready_o (hdr_ready),
        .dst_addr_i  (hdr_dst),
        .src_addr_i  (hdr_src),
        .frame_len_i (hdr_len),
        .sel_valid_o (sel_valid),
        .sel_port_o  (sel_port),
        .sel_dst_o   (sel_dst),
        .sel_src_o   (sel_src),
        .sel_len_o   (sel_len),
        .sel_ready_i (sel_ready)
    );

    address_table u_table (
        .switch_clk     (switch_clk),
        .rst_n_i        (rst_n_i),
        .sel_valid_i    (sel_valid),
        .sel_port_i     (sel_port),
        .sel_dst_i      (sel_dst),
        .sel_src_i      (sel_src),
        .sel_len_i      (sel_len),
        .sel_ready_o    (sel_ready),
        .fwd_valid_o    (fwd_valid),
        .fwd_mask_o     (fwd_mask),
        .fwd_src_port_o (fwd_src_port),
        .fwd_len_o      (fwd_len),
        .fwd_ready_i    (fwd_ready)
    );

    forward_queue u_queue (
        .switch_clk      (switch_clk),
        .rst_n_i         (rst_n_i),
        .fwd_valid_i     (fwd_valid),
        .fwd_mask_i      (fwd_mask),
        .fwd_src_port_i  (fwd_src_port),
        .fwd_len_i       (fwd_len),
        .fwd_ready_o     (fwd_ready),
        .desc_valid_o    (desc_valid_o),
        .desc_mask_o     (desc_mask_o),
        .desc_src_port_o (desc_src_port_o),
        .desc_len_o      (desc_len_o),
        .desc_ready_i    (desc_ready_i)
    );

endmodule

/* bench/switch_core_sva.sv */
`timescale 1ns/1ps

module switch_core_sva (
    input logic                             switch_clk,
    input logic                             rst_n_i,
    input logic                             sel_valid_i,
    input logic                             sel_ready_i,
    input logic [switch_pkg::PORT_W-1:0]    sel_port_i,
    input logic [mac_pkg::MAC_W-1:0]        sel_dst_i,
    input logic [mac_pkg::MAC_W-1:0]        sel_src_i,
    input logic [switch_pkg::LEN_W-1:0]     sel_len_i,
    input logic                             desc_valid_i,
    input logic                             desc_ready_i,
    input logic [switch_pkg::NUM_PORTS-1:0] desc_mask_i,
    input logic [switch_pkg::PORT_W-1:0]    desc_src_port_i,
    input logic [switch_pkg::LEN_W-1:0]     desc_len_i
);

    // stalled header keeps its grant and contents
    a_sel_hold: assert property (@(posedge switch_clk) disable iff (!rst_n_i)
        sel_valid_i && !sel_ready_i |=> sel_valid_i && $stable(sel_port_i)
            && $stable(sel_dst_i) && $stable(sel_src_i) && $stable(sel_len_i))
        else $error("held header changed before acceptance");

    // stalled descriptor stays put
    a_desc_hold: assert property (@(posedge switch_clk) disable iff (!rst_n_i)
        desc_valid_i && !desc_ready_i |=> desc_valid_i && $stable(desc_mask_i)
            && $stable(desc_src_port_i) && $stable(desc_len_i))
        else $error("held descriptor changed before acceptance");

    a_reset_idle: assert property (@(posedge switch_clk) !rst_n_i |=> !desc_valid_i)
        else $error("descriptor valid after reset");

    // never send a frame back out its ingress port
    a_no_echo: assert property (@(posedge switch_clk) disable iff (!rst_n_i)
        desc_valid_i |-> !desc_mask_i[desc_src_port_i])
        else $error("descriptor mask includes its source port");

endmodule

/* bench/switch_core_tb.sv */
`timescale 1ns/1ps

module switch_core_tb;
    import switch_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_FRAMES   = 64;
    // cycles allowed per frame on top of its bytes
    localparam int FRAME_SLACK  = 40;

    logic                  switch_clk;
    logic                  rst_n;
    logic [DATA_WIDTH-1:0] rx_data [NUM_PORTS];
    logic                  rx_valid [NUM_PORTS];
    logic                  rx_sof [NUM_PORTS];
    logic                  rx_eof [NUM_PORTS];
    logic                  rx_error [NUM_PORTS];
    logic                  rx_ready [NUM_PORTS];
    logic                  desc_valid;
    logic [NUM_PORTS-1:0]  desc_mask;
    logic [PORT_W-1:0]     desc_src_port;
    logic [LEN_W-1:0]      desc_len;
    logic                  desc_ready;

    // frame table loaded from the stimulus file
    int                    f_round [MAX_FRAMES];
    int                    f_port [MAX_FRAMES];
    logic [47:0]           f_dst [MAX_FRAMES];
    logic [47:0]           f_src [MAX_FRAMES];
    int                    f_len [MAX_FRAMES];
    int                    f_err [MAX_FRAMES];
    logic [NUM_PORTS-1:0]  f_mask [MAX_FRAMES];
    int                    num_frames = 0;
    int                    total_bytes = 0;

    // expected descriptors per source port in arrival order
    logic [DESC_W-1:0]     exp_q [NUM_PORTS][$];

    logic [15:0]           lfsr_q = 16'd30028;
    int                    cycle_count = 0;
    int                    limit_cycles = 0;
    int                    error_count = 0;

    switch_core DUT (
        .switch_clk      (switch_clk),
        .rst_n_i         (rst_n),
        .rx_data_i       (rx_data),
        .rx_valid_i      (rx_valid),
        .rx_sof_i        (rx_sof),
        .rx_eof_i        (rx_eof),
        .rx_error_i      (rx_error),
        .rx_ready_o      (rx_ready),
        .desc_valid_o    (desc_valid),
        .desc_mask_o     (desc_mask),
        .desc_src_port_o (desc_src_port),
        .desc_len_o      (desc_len),
        .desc_ready_i    (desc_ready)
    );

    bind switch_core switch_core_sva u_sva (
        .switch_clk      (switch_clk),
        .rst_n_i         (rst_n_i),
        .sel_valid_i     (sel_valid),
        .sel_ready_i     (sel_ready),
        .sel_port_i      (sel_port),
        .sel_dst_i       (sel_dst),
        .sel_src_i       (sel_src),
        .sel_len_i       (sel_len),
        .desc_valid_i    (desc_valid_o),
        .desc_ready_i    (desc_ready_i),
        .desc_mask_i     (desc_mask_o),
        .desc_src_port_i (desc_src_port_o),
        .desc_len_i      (desc_len_o)
    );

    initial begin
        switch_clk = 1'b0;
        forever #20 switch_clk = ~switch_clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    task automatic abort_run();
        error_count++;
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_mask(input logic [NUM_PORTS-1:0] got, input logic [NUM_PORTS-1:0] exp);
        if (got !== exp) begin
            $display("FAILED desc_mask_o got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_port(input logic [PORT_W-1:0] got, input logic [PORT_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED desc_src_port_o got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic check_len(input logic [LEN_W-1:0] got, input logic [LEN_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED desc_len_o got %h expected %h", got, exp);
            abort_run();
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    n;
        string line_s;
        fd = $fopen("bench/frame_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            abort_run();
        end
        while (!$feof(fd) && num_frames < MAX_FRAMES) begin
            n = $fgets(line_s, fd);
            // skip blank and comment lines
            if (n > 0 && line_s.len() > 1 && line_s.getc(0) != "#") begin
                n = $sscanf(line_s, "%h %h %h %h %h %h %h", f_round[num_frames],
                            f_port[num_frames], f_dst[num_frames], f_src[num_frames],
                            f_len[num_frames], f_err[num_frames], f_mask[num_frames]);
                if (n == 7) begin
                    total_bytes += f_len[num_frames];
                    num_frames++;
                end
            end
        end
        $fclose(fd);
    endtask

    // dst and src msb first then a counting filler
    function automatic logic [7:0] frame_byte(input int k, input int i);
        if (i < 6) begin
            return f_dst[k][47 - 8 * i -: 8];
        end else if (i < 12) begin
            return f_src[k][47 - 8 * (i - 6) -: 8];
        end
        return 8'(i);
    endfunction

    // starts on a falling edge and returns on the one after eof
    task automatic send_frame(input int k);
        int p;
        p = f_port[k];
        for (int i = 0; i < f_len[k]; i++) begin
            // idle beat with 1 in 4 chance
            while (lfsr_bit() & lfsr_bit()) begin
                rx_valid[p] = 1'b0;
                @(negedge switch_clk);
            end
            rx_valid[p] = 1'b1;
            rx_data[p]  = frame_byte(k, i);
            rx_sof[p]   = (i == 0);
            rx_eof[p]   = (i == f_len[k] - 1);
            // bad byte is the last destination byte
            rx_error[p] = (f_err[k] != 0) && (i == 5);
            while (!rx_ready[p]) begin
                @(negedge switch_clk);
            end
            @(negedge switch_clk);
        end
        rx_valid[p] = 1'b0;
        rx_sof[p]   = 1'b0;
        rx_eof[p]   = 1'b0;
        rx_error[p] = 1'b0;
    endtask

    task automatic send_port(input int rnd, input int p);
        for (int k = 0; k < num_frames; k++) begin
            if (f_round[k] == rnd && f_port[k] == p) begin
                // zero mask marks a frame with no descriptor
                if (f_mask[k] != '0) begin
                    exp_q[p].push_back({f_mask[k], PORT_W'(p), LEN_W'(f_len[k])});
                end
                send_frame(k);
            end
        end
    endtask

    // all parsers free means every header of the round was learned
    function automatic logic headers_taken();
        logic idle;
        idle = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            idle = idle && rx_ready[p];
        end
        return idle;
    endfunction

    // nothing left in the DUT queue or in the expected queues
    function automatic logic all_drained();
        logic empty;
        empty = !desc_valid;
        for (int p = 0; p < NUM_PORTS; p++) begin
            empty = empty && (exp_q[p].size() == 0);
        end
        return empty;
    endfunction

    // next round may start once the table holds this round's sources
    task automatic wait_round_done();
        @(negedge switch_clk);
        while (!headers_taken()) begin
            @(negedge switch_clk);
        end
    endtask

    task automatic wait_drained();
        @(negedge switch_clk);
        while (!all_drained()) begin
            @(negedge switch_clk);
        end
    endtask

    // descriptor side is driven and sampled on the falling edge
    initial begin
        int                   p;
        logic [NUM_PORTS-1:0] exp_mask;
        logic [PORT_W-1:0]    exp_port;
        logic [LEN_W-1:0]     exp_len;
        forever begin
            @(negedge switch_clk);
            // random gaps plus long low windows that fill the queue
            desc_ready = lfsr_bit() && !cycle_count[7];
            // this handshake completes on the coming rising edge
            if (rst_n && desc_valid && desc_ready) begin
                p = int'(desc_src_port);
                if (exp_q[p].size() == 0) begin
                    $display("descriptor from port %0d arrived with none expected", p);
                    abort_run();
                end else begin
                    {exp_mask, exp_port, exp_len} = exp_q[p].pop_front();
                    check_mask(desc_mask, exp_mask);
                    check_port(desc_src_port, exp_port);
                    check_len(desc_len, exp_len);
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge switch_clk);
            cycle_count++;
            if (limit_cycles > 0 && cycle_count > limit_cycles) begin
                $display("timeout, run still busy after %0d cycles", cycle_count);
                abort_run();
            end
        end
    end

    initial begin
        int max_round;
        rst_n      = 1'b0;
        desc_ready = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            rx_data[p]  = '0;
            rx_valid[p] = 1'b0;
            rx_sof[p]   = 1'b0;
            rx_eof[p]   = 1'b0;
            rx_error[p] = 1'b0;
        end
        load_stimulus();
        if (num_frames == 0) begin
            $display("stimulus file holds no frames");
            abort_run();
        end
        max_round = 0;
        for (int k = 0; k < num_frames; k++) begin
            if (f_round[k] > max_round) begin
                max_round = f_round[k];
            end
        end
        limit_cycles = RESET_CYCLES + total_bytes + FRAME_SLACK * num_frames;
        repeat (RESET_CYCLES) @(negedge switch_clk);
        rst_n = 1'b1;
        // ports of one round run in parallel
        for (int r = 1; r <= max_round; r++) begin
            fork
                send_port(r, 0);
                send_port(r, 1);
                send_port(r, 2);
                send_port(r, 3);
            join
            wait_round_done();
        end
        wait_drained();
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* bench/frame_stimulus.txt */
# round port dst src len err mask, all hex; mask 0 means no descriptor expected
# bytes are dst, src, then filler; err flags byte 5 of the frame as bad
1 0 020000000011 020000000001 40 0 e
2 1 020000000001 020000000002 3c 0 1
2 2 020000000011 020000000003 2e 0 b
3 3 020000000002 020000000004 0e 0 2
3 0 020000000003 020000000001 48 0 4
3 2 ffffffffffff 020000000003 30 0 b
3 1 01005e000001 020000000002 22 0 d
4 2 020000000005 020000000002 26 0 b
4 3 020000000004 020000000004 20 0 0
4 0 020000000002 020000000021 20 1 0
4 1 020000000002 020000000022 0d 0 0
5 0 020000000002 020000000001 1a 0 4
5 1 020000000021 020000000005 2c 0 d
5 3 020000000022 020000000004 16 0 7
6 0 020000000003 020000000031 14 0 4
6 1 020000000001 020000000032 18 0 1
6 2 020000000004 020000000033 1c 0 8
6 3 020000000005 020000000034 12 0 2
7 0 020000000005 020000000035 15 0 2
7 1 020000000003 020000000036 19 0 4
7 2 020000000001 020000000037 1d 0 1
7 3 020000000002 020000000038 13 0 4
8 0 ffffffffffff 020000000039 24 0 e
8 1 020000000004 02000000003a 28 0 8
8 2 020000000011 02000000003b 2a 0 b
9 3 020000000001 02000000003c 3e 0 1
a 1 020000000001 020000000005 40 0 d
a 2 02000000003c 020000000003 33 0 8
a 0 020000000032 020000000031 1f 0 2

/* switch_core.f */
logic/switch_pkg.sv
logic/mac_pkg.sv
logic/frame_header_parser.sv
logic/header_arbiter.sv
logic/address_table.sv
logic/forward_queue.sv
logic/switch_core.sv
bench/switch_core_sva.sv
bench/switch_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the switch_core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module switch_core_tb \
    -f switch_core.f -o sim_switch_core
status=0
./obj_dir/sim_switch_core > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "Checks failed" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
